/* logic/htu_pkg.sv */
`default_nettype none

package htu_pkg;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int TAG_LSB    = 10;
  localparam int SET_LSB    = 8;
  localparam int OFFSET_BIT = 7;
  localparam int NUM_WAYS   = 8;
  localparam int NUM_SETS   = 4;

  localparam int TAG_W  = ADDR_W - TAG_LSB;
  localparam int SET_W  = TAG_LSB - SET_LSB;
  localparam int WAY_W  = $clog2(NUM_WAYS);
  localparam int PLRU_W = NUM_WAYS - 1;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [SET_W-1:0]    set_idx_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [NUM_WAYS-1:0] way_vec_t;
  typedef logic [PLRU_W-1:0]   plru_t;
  typedef logic [1:0]          ofs_state_t;

  // half-line states, 11 is unused
  localparam ofs_state_t ST_INVALID = 2'b00;
  localparam ofs_state_t ST_CLEAN   = 2'b01;
  localparam ofs_state_t ST_DIRTY   = 2'b10;

  typedef enum logic [1:0] {
    OP_READ       = 2'd0,
    OP_WRITE      = 2'd1,
    OP_FLUSH      = 2'd2,
    OP_INVALIDATE = 2'd3
  } htu_op_e;

  typedef struct packed {
    htu_op_e  op;
    tag_t     tag;
    set_idx_t set_idx;
    logic     offset;
  } htu_cmd_s;

  typedef struct packed {
    logic       hit;
    logic       need_evict;
    way_t       way;
    ofs_state_t offset0;
    ofs_state_t offset1;
    tag_t       evict_tag;
  } htu_lookup_s;

  // ----------------------------------------------------------
  // result word as seen on the R channel
  // ----------------------------------------------------------
  localparam int RES_HIT_BIT   = 0;
  localparam int RES_EVICT_BIT = 1;
  localparam int RES_WAY_LSB   = 2;
  localparam int RES_OFS0_LSB  = 5;
  localparam int RES_OFS1_LSB  = 7;
  localparam int RES_TAG_LSB   = 10;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // one-hot way vector to way number
  function automatic way_t way_from_vec(way_vec_t vec);
    way_t way;
    way = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (vec[i]) begin
        way = way_t'(i);
      end
    end
    return way;
  endfunction

endpackage

`default_nettype wire

/* logic/bank_htu_cacheline.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_cacheline (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       access_valid_i,
  input  wire htu_pkg::htu_op_e     op_i,
  input  wire                       access_offset_i,
  input  wire htu_pkg::tag_t        access_tag_i,
  input  wire                       allocate_i,
  output logic                      valid_o,
  output htu_pkg::tag_t             tag_o,
  output logic                      hit_o,
  output htu_pkg::ofs_state_t       offset0_state_o,
  output htu_pkg::ofs_state_t       offset1_state_o
);
  import htu_pkg::*;

  tag_t             tag_q;
  tag_t             tag_d;
  ofs_state_t [1:0] ofs_q;
  ofs_state_t [1:0] ofs_d;
  logic             is_rw;

  assign valid_o         = (ofs_q[0] != ST_INVALID) || (ofs_q[1] != ST_INVALID);
  assign hit_o           = valid_o && (tag_q == access_tag_i);
  assign tag_o           = tag_q;
  assign offset0_state_o = ofs_q[0];
  assign offset1_state_o = ofs_q[1];
  assign is_rw           = (op_i == OP_READ) || (op_i == OP_WRITE);

  // next state of the way for the current access
  always_comb begin
    tag_d = tag_q;
    ofs_d = ofs_q;
    if (hit_o) begin
      case (op_i)
        OP_READ: begin
          if (ofs_q[access_offset_i] == ST_INVALID) begin
            ofs_d[access_offset_i] = ST_CLEAN;
          end
        end
        OP_WRITE: begin
          ofs_d[access_offset_i] = ST_DIRTY;
        end
        OP_FLUSH: begin
          for (int i = 0; i < 2; i++) begin
            if (ofs_q[i] == ST_DIRTY) begin
              ofs_d[i] = ST_CLEAN;
            end
          end
        end
        OP_INVALIDATE: begin
          ofs_d = {ST_INVALID, ST_INVALID};
        end
      endcase
    end else if (allocate_i && is_rw) begin
      // refill, only the accessed half is present
      tag_d                   = access_tag_i;
      ofs_d[~access_offset_i] = ST_INVALID;
      ofs_d[access_offset_i]  = (op_i == OP_WRITE) ? ST_DIRTY : ST_CLEAN;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_q <= '0;
      ofs_q <= {ST_INVALID, ST_INVALID};
    end else if (access_valid_i) begin
      tag_q <= tag_d;
      ofs_q <= ofs_d;
    end
  end

  a_no_unused_code: assert property (@(posedge clk_i) disable iff (reset_i)
    (ofs_q[0] != 2'b11) && (ofs_q[1] != 2'b11));

endmodule

`default_nettype wire

/* logic/bank_htu_plru_tree.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_plru_tree (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       access_valid_i,
  input  wire htu_pkg::way_vec_t    access_array_i,
  output htu_pkg::way_vec_t         oldest_way_array_o
);
  import htu_pkg::*;

  // node 0 is the root, 1..2 the middle level, 3..6 the leaves
  plru_t tree_q;
  way_t  acc_way;
  logic  root_b;
  logic  mid_b;
  logic  leaf_b;

  assign acc_way = way_from_vec(access_array_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tree_q <= '0;
    end else if (access_valid_i) begin
      // path nodes point away from the accessed way
      tree_q[0]                <= ~acc_way[2];
      tree_q[1 + acc_way[2]]   <= ~acc_way[1];
      tree_q[3 + acc_way[2:1]] <= ~acc_way[0];
    end
  end

  // walk towards the oldest way, 0 selects the lower half
  assign root_b = tree_q[0];
  assign mid_b  = tree_q[1 + root_b];
  assign leaf_b = tree_q[3 + {root_b, mid_b}];

  assign oldest_way_array_o = way_vec_t'(1) << {root_b, mid_b, leaf_b};

  a_oldest_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot(oldest_way_array_o));

endmodule

`default_nettype wire

/* logic/bank_htu_set_entry.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_set_entry (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       set_hit_wv_i,
  input  wire htu_pkg::htu_cmd_s    cmd_i,
  output htu_pkg::htu_lookup_s      lookup_o
);
  import htu_pkg::*;

  way_vec_t   hit_vec;
  way_vec_t   victim_vec;
  way_vec_t   access_vec;
  way_vec_t   alloc_vec;
  tag_t       tag_arr  [NUM_WAYS];
  ofs_state_t ofs0_arr [NUM_WAYS];
  ofs_state_t ofs1_arr [NUM_WAYS];
  logic       set_hit;
  logic       victim_dirty;
  way_t       access_way;
  way_t       victim_way;

  assign set_hit = |hit_vec;

  // hit way on a hit or the tree victim on a miss
  assign access_vec = set_hit ? hit_vec : victim_vec;
  assign alloc_vec  = victim_vec & {NUM_WAYS{set_hit_wv_i & ~set_hit}};

  assign access_way = way_from_vec(access_vec);
  assign victim_way = way_from_vec(victim_vec);

  // any dirty half of the victim needs a write-back
  assign victim_dirty = (ofs0_arr[victim_way] == ST_DIRTY)
                     || (ofs1_arr[victim_way] == ST_DIRTY);

  assign lookup_o = '{
    hit:        set_hit,
    need_evict: victim_dirty,
    way:        access_way,
    offset0:    ofs0_arr[access_way],
    offset1:    ofs1_arr[access_way],
    evict_tag:  tag_arr[victim_way]
  };

  // ----------------------------------------------------------
  // ways
  // ----------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    bank_htu_cacheline u_cacheline (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .access_valid_i  (set_hit_wv_i),
      .op_i            (cmd_i.op),
      .access_offset_i (cmd_i.offset),
      .access_tag_i    (cmd_i.tag),
      .allocate_i      (alloc_vec[w]),
      .valid_o         (),
      .tag_o           (tag_arr[w]),
      .hit_o           (hit_vec[w]),
      .offset0_state_o (ofs0_arr[w]),
      .offset1_state_o (ofs1_arr[w])
    );
  end

  // ----------------------------------------------------------
  // replacement
  // ----------------------------------------------------------
  bank_htu_plru_tree u_plru_tree (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .access_valid_i     (set_hit_wv_i),
    .access_array_i     (access_vec),
    .oldest_way_array_o (victim_vec)
  );

  // a tag lives in at most one way of the set
  a_single_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    set_hit_wv_i |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

/* logic/bank_htu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_decode (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          awvalid_i,
  input  wire htu_pkg::addr_t          awaddr_i,
  input  wire                          wvalid_i,
  input  wire [31:0]                   wdata_i,
  input  wire                          cmd_done_i,
  output logic                         awready_o,
  output logic                         wready_o,
  output htu_pkg::htu_cmd_s            cmd_o,
  output logic                         cmd_valid_o,
  output logic [htu_pkg::NUM_SETS-1:0] set_sel_o
);
  import htu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_COLLECT,
    S_ISSUE,
    S_WAIT_RSP
  } dec_state_e;

  dec_state_e state_q;
  dec_state_e state_d;
  logic       aw_taken_q;
  logic       w_taken_q;
  logic       aw_hs;
  logic       w_hs;
  logic       collecting;
  htu_cmd_s   cmd_q;

  assign collecting = (state_q == S_IDLE) || (state_q == S_COLLECT);
  assign awready_o  = collecting && !aw_taken_q;
  assign wready_o   = collecting && !w_taken_q;
  assign aw_hs      = awvalid_i && awready_o;
  assign w_hs       = wvalid_i && wready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE, S_COLLECT: begin
        if ((aw_taken_q || aw_hs) && (w_taken_q || w_hs)) begin
          state_d = S_ISSUE;
        end else if (aw_hs || w_hs) begin
          state_d = S_COLLECT;
        end
      end
      S_ISSUE: begin
        state_d = S_WAIT_RSP;
      end
      S_WAIT_RSP: begin
        if (cmd_done_i) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      aw_taken_q <= 1'b0;
      w_taken_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == S_IDLE) begin
        aw_taken_q <= 1'b0;
        w_taken_q  <= 1'b0;
      end else begin
        aw_taken_q <= aw_taken_q | aw_hs;
        w_taken_q  <= w_taken_q | w_hs;
      end
    end
  end

  // address split and opcode capture
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      cmd_q.tag     <= awaddr_i[TAG_LSB +: TAG_W];
      cmd_q.set_idx <= awaddr_i[SET_LSB +: SET_W];
      cmd_q.offset  <= awaddr_i[OFFSET_BIT];
    end
    if (w_hs) begin
      cmd_q.op <= htu_op_e'(wdata_i[1:0]);
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = (state_q == S_ISSUE);
  assign set_sel_o   = {NUM_SETS{cmd_valid_o}} & (NUM_SETS'(1) << cmd_q.set_idx);

  a_single_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

`default_nettype wire

/* logic/bank_htu_result.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_result (
  input  wire                                             clk_i,
  input  wire                                             reset_i,
  input  wire                                             cmd_valid_i,
  input  wire htu_pkg::set_idx_t                          set_idx_i,
  input  wire htu_pkg::htu_lookup_s [htu_pkg::NUM_SETS-1:0] lookup_i,
  input  wire                                             bready_i,
  input  wire                                             arvalid_i,
  input  wire                                             rready_i,
  output logic                                            bvalid_o,
  output logic [1:0]                                      bresp_o,
  output logic                                            arready_o,
  output logic                                            rvalid_o,
  output logic [31:0]                                     rdata_o,
  output logic [1:0]                                      rresp_o,
  output logic                                            cmd_done_o
);
  import htu_pkg::*;

  htu_lookup_s sel;
  logic [31:0] res_word;
  logic [31:0] result_q;
  logic [31:0] rdata_q;
  logic        bvalid_q;
  logic        rvalid_q;
  logic        ar_hs;

  assign sel = lookup_i[set_idx_i];

  always_comb begin
    res_word                             = '0;
    res_word[RES_HIT_BIT]                = sel.hit;
    // write-back only matters when a miss replaces the victim
    res_word[RES_EVICT_BIT]              = sel.need_evict && !sel.hit;
    res_word[RES_WAY_LSB +: WAY_W]       = sel.way;
    res_word[RES_OFS0_LSB +: 2]          = sel.offset0;
    res_word[RES_OFS1_LSB +: 2]          = sel.offset1;
    res_word[RES_TAG_LSB +: TAG_W]       = sel.evict_tag;
  end

  // ----------------------------------------------------------
  // write response
  // ----------------------------------------------------------
  assign cmd_done_o = bvalid_q && bready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
      bvalid_q <= 1'b0;
    end else if (cmd_valid_i) begin
      result_q <= res_word;
      bvalid_q <= 1'b1;
    end else if (cmd_done_o) begin
      bvalid_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // read channel
  // ----------------------------------------------------------
  assign ar_hs = arvalid_i && arready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // hold read data steady while the host stalls
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= result_q;
    end
  end

  assign bvalid_o  = bvalid_q;
  assign bresp_o   = RESP_OKAY;
  assign arready_o = !rvalid_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = RESP_OKAY;

endmodule

`default_nettype wire

/* logic/bank_htu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_top (
  input  wire                 clk_i,
  input  wire                 reset_i,
  input  wire                 s_awvalid_i,
  output logic                s_awready_o,
  input  wire htu_pkg::addr_t s_awaddr_i,
  input  wire                 s_wvalid_i,
  output logic                s_wready_o,
  input  wire [31:0]          s_wdata_i,
  output logic                s_bvalid_o,
  input  wire                 s_bready_i,
  output logic [1:0]          s_bresp_o,
  input  wire                 s_arvalid_i,
  output logic                s_arready_o,
  output logic                s_rvalid_o,
  input  wire                 s_rready_i,
  output logic [31:0]         s_rdata_o,
  output logic [1:0]          s_rresp_o
);
  import htu_pkg::*;

  htu_cmd_s                   cmd;
  logic                       cmd_valid;
  logic                       cmd_done;
  logic [NUM_SETS-1:0]        set_sel;
  htu_lookup_s [NUM_SETS-1:0] lookups;

  bank_htu_decode u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .awvalid_i   (s_awvalid_i),
    .awaddr_i    (s_awaddr_i),
    .wvalid_i    (s_wvalid_i),
    .wdata_i     (s_wdata_i),
    .cmd_done_i  (cmd_done),
    .awready_o   (s_awready_o),
    .wready_o    (s_wready_o),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid),
    .set_sel_o   (set_sel)
  );

  // one entry per set, only the selected one updates
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    bank_htu_set_entry u_set_entry (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .set_hit_wv_i (set_sel[s]),
      .cmd_i        (cmd),
      .lookup_o     (lookups[s])
    );
  end

  bank_htu_result u_result (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid),
    .set_idx_i   (cmd.set_idx),
    .lookup_i    (lookups),
    .bready_i    (s_bready_i),
    .arvalid_i   (s_arvalid_i),
    .rready_i    (s_rready_i),
    .bvalid_o    (s_bvalid_o),
    .bresp_o     (s_bresp_o),
    .arready_o   (s_arready_o),
    .rvalid_o    (s_rvalid_o),
    .rdata_o     (s_rdata_o),
    .rresp_o     (s_rresp_o),
    .cmd_done_o  (cmd_done)
  );

endmodule

`default_nettype wire

/* tests/bank_htu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_htu_tb;
  import htu_pkg::*;

  localparam int N_RANDOM       = 200;
  localparam int N_CMDS         = N_RANDOM + 50;
  localparam int CYC_PER_CMD    = 8;
  localparam int TIMEOUT_CYCLES = 4 * N_CMDS * CYC_PER_CMD;

  logic        clk;
  logic        reset;
  logic        awvalid;
  addr_t       awaddr;
  logic        wvalid;
  logic [31:0] wdata;
  logic        bready;
  logic        arvalid;
  logic        rready;
  logic        s_awready;
  logic        s_wready;
  logic        s_bvalid;
  logic [1:0]  s_bresp;
  logic        s_arready;
  logic        s_rvalid;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;

  logic [31:0] exp_word;
  logic [31:0] rng_state;
  int          cycle_cnt;

  // reference model of all four sets
  tag_t        m_tag  [NUM_SETS][NUM_WAYS];
  ofs_state_t  m_st   [NUM_SETS][NUM_WAYS][2];
  plru_t       m_tree [NUM_SETS];

  bank_htu_top u_bank_htu_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .s_awvalid_i (awvalid),
    .s_awready_o (s_awready),
    .s_awaddr_i  (awaddr),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (s_wready),
    .s_wdata_i   (wdata),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (bready),
    .s_bresp_o   (s_bresp),
    .s_arvalid_i (arvalid),
    .s_arready_o (s_arready),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (rready),
    .s_rdata_o   (s_rdata),
    .s_rresp_o   (s_rresp)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_rdata: assert property (@(posedge clk) disable iff (reset)
    s_rvalid && rready |-> s_rdata == exp_word)
    else stop_with_failure($sformatf("Mismatch at %0t: s_rdata is %h, expected %h",
                                     $time, $sampled(s_rdata), exp_word));

  a_r_hold: assert property (@(posedge clk) disable iff (reset)
    s_rvalid && !rready |=> s_rvalid && $stable(s_rdata))
    else stop_with_failure($sformatf("read data changed while stalled at %0t", $time));

  a_ar_block: assert property (@(posedge clk) disable iff (reset)
    s_rvalid |-> !s_arready)
    else stop_with_failure($sformatf("arready high while a read is pending at %0t", $time));

  a_b_hold: assert property (@(posedge clk) disable iff (reset)
    s_bvalid && !bready |=> s_bvalid)
    else stop_with_failure($sformatf("bvalid dropped before the B handshake at %0t", $time));

  a_b_blocks: assert property (@(posedge clk) disable iff (reset)
    s_bvalid |-> !s_awready && !s_wready)
    else stop_with_failure($sformatf("write beat accepted during a pending B at %0t", $time));

  a_bresp: assert property (@(posedge clk) disable iff (reset)
    s_bvalid |-> s_bresp == 2'b00)
    else stop_with_failure($sformatf("bresp is not OKAY at %0t", $time));

  a_rresp: assert property (@(posedge clk) disable iff (reset)
    s_rvalid |-> s_rresp == 2'b00)
    else stop_with_failure($sformatf("rresp is not OKAY at %0t", $time));

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ------------------------------------------------------------
  // model
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input set_idx_t s, input logic ofs);
    return {tag, s, ofs, 7'd0};
  endfunction

  // result word for one command before the model steps forward
  function automatic logic [31:0] predict(input addr_t addr, input htu_op_e op);
    tag_t        tag;
    set_idx_t    s;
    logic        ofs;
    logic        hit;
    logic [2:0]  hit_way;
    logic [2:0]  vic;
    logic [2:0]  way;
    logic        dirty;
    logic [31:0] word;
    tag = addr[31:10];
    s   = addr[9:8];
    ofs = addr[7];
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if ((m_st[s][w][0] != ST_INVALID || m_st[s][w][1] != ST_INVALID)
          && m_tag[s][w] == tag) begin
        hit = 1'b1;
        hit_way = 3'(w);
      end
    end
    // walk the tree where a 0 node goes to the lower half
    vic[2] = m_tree[s][0];
    vic[1] = m_tree[s][1 + vic[2]];
    vic[0] = m_tree[s][3 + vic[2:1]];
    way    = hit ? hit_way : vic;
    dirty  = (m_st[s][vic][0] == ST_DIRTY) || (m_st[s][vic][1] == ST_DIRTY);
    word = '0;
    word[0]     = hit;
    word[1]     = dirty && !hit;
    word[4:2]   = way;
    word[6:5]   = m_st[s][way][0];
    word[8:7]   = m_st[s][way][1];
    word[31:10] = m_tag[s][vic];
    if (hit) begin
      case (op)
        OP_READ: begin
          if (m_st[s][way][ofs] == ST_INVALID) begin
            m_st[s][way][ofs] = ST_CLEAN;
          end
        end
        OP_WRITE: begin
          m_st[s][way][ofs] = ST_DIRTY;
        end
        OP_FLUSH: begin
          for (int i = 0; i < 2; i++) begin
            if (m_st[s][way][i] == ST_DIRTY) begin
              m_st[s][way][i] = ST_CLEAN;
            end
          end
        end
        default: begin
          m_st[s][way][0] = ST_INVALID;
          m_st[s][way][1] = ST_INVALID;
        end
      endcase
    end else if (op == OP_READ || op == OP_WRITE) begin
      m_tag[s][way]      = tag;
      m_st[s][way][!ofs] = ST_INVALID;
      m_st[s][way][ofs]  = (op == OP_WRITE) ? ST_DIRTY : ST_CLEAN;
    end
    // path nodes point away from the used way
    m_tree[s][0]              = ~way[2];
    m_tree[s][1 + way[2]]     = ~way[1];
    m_tree[s][3 + way[2:1]]   = ~way[0];
    return word;
  endfunction

  // ------------------------------------------------------------
  // bus tasks that start just after a rising edge
  // ------------------------------------------------------------
  task automatic put_aw(input addr_t addr);
    awvalid <= 1'b1;
    awaddr  <= addr;
    do @(negedge clk); while (!s_awready);
    @(posedge clk);
    awvalid <= 1'b0;
  endtask

  task automatic put_w(input htu_op_e op);
    wvalid <= 1'b1;
    wdata  <= {30'd0, op};
    do @(negedge clk); while (!s_wready);
    @(posedge clk);
    wvalid <= 1'b0;
  endtask

  // skew 0 sends both beats together, 1 sends AW first and 2 sends W first
  task automatic issue_beats(input addr_t addr, input htu_op_e op, input int skew);
    case (skew)
      0: begin
        fork
          put_aw(addr);
          put_w(op);
        join
      end
      1: begin
        put_aw(addr);
        put_w(op);
      end
      default: begin
        put_w(op);
        put_aw(addr);
      end
    endcase
  endtask

  task automatic finish_b();
    do @(negedge clk); while (!(s_bvalid && bready));
    @(posedge clk);
  endtask

  task automatic read_result(input logic [31:0] expected, input int stall);
    exp_word = expected;
    arvalid <= 1'b1;
    do @(negedge clk); while (!s_arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!s_rvalid);
    repeat (stall) @(negedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic run_cmd(input addr_t addr, input htu_op_e op, input int skew, input int stall);
    logic [31:0] expected;
    expected = predict(addr, op);
    issue_beats(addr, op, skew);
    finish_b();
    read_result(expected, stall);
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] expected;
    clk       = 1'b0;
    reset     = 1'b1;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b1;
    arvalid   = 1'b0;
    rready    = 1'b0;
    exp_word  = '0;
    rng_state = 32'd83;
    cycle_cnt = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_tree[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]   = '0;
        m_st[s][w][0] = ST_INVALID;
        m_st[s][w][1] = ST_INVALID;
      end
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // empty set miss and then a hit on the same line
    run_cmd(make_addr(22'h100, 2'd0, 1'b0), OP_READ, 0, 0);
    run_cmd(make_addr(22'h100, 2'd0, 1'b0), OP_READ, 1, 1);

    // fill one set and revisit every tag
    for (int i = 0; i < 8; i++) begin
      run_cmd(make_addr(22'h200 + 22'(i), 2'd1, 1'b1), OP_READ, i % 3, 0);
    end
    for (int i = 0; i < 8; i++) begin
      run_cmd(make_addr(22'h200 + 22'(i), 2'd1, 1'b0), OP_READ, 2, 0);
    end

    // dirty way comes round as the victim
    run_cmd(make_addr(22'h300, 2'd2, 1'b1), OP_WRITE, 2, 0);
    for (int i = 1; i <= 8; i++) begin
      run_cmd(make_addr(22'h300 + 22'(i), 2'd2, 1'b0), OP_READ, 0, 0);
    end

    // flushed way evicts clean and an invalidated tag misses
    run_cmd(make_addr(22'h400, 2'd3, 1'b0), OP_WRITE, 0, 0);
    run_cmd(make_addr(22'h400, 2'd3, 1'b0), OP_FLUSH, 1, 0);
    for (int i = 1; i <= 8; i++) begin
      run_cmd(make_addr(22'h400 + 22'(i), 2'd3, 1'b1), OP_READ, 0, 0);
    end
    run_cmd(make_addr(22'h405, 2'd3, 1'b1), OP_INVALIDATE, 2, 0);
    run_cmd(make_addr(22'h405, 2'd3, 1'b1), OP_READ, 0, 0);

    // B held off while a second command waits on the bus
    expected = predict(make_addr(22'h100, 2'd0, 1'b1), OP_WRITE);
    bready <= 1'b0;
    issue_beats(make_addr(22'h100, 2'd0, 1'b1), OP_WRITE, 0);
    awvalid <= 1'b1;
    awaddr  <= make_addr(22'h100, 2'd0, 1'b1);
    wvalid  <= 1'b1;
    wdata   <= {30'd0, OP_INVALIDATE};
    repeat (6) @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    finish_b();
    read_result(expected, 3);
    run_cmd(make_addr(22'h100, 2'd0, 1'b1), OP_READ, 0, 0);

    // random traffic over a small tag pool
    for (int i = 0; i < N_RANDOM; i++) begin
      r = xorshift32();
      run_cmd(make_addr(22'h500 + 22'(r[11:8] % 12), r[13:12], r[14]),
              htu_op_e'(r[17:16]), int'(r[21:20]) % 3, int'(r[23]));
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/htu_pkg.sv
logic/bank_htu_cacheline.sv
logic/bank_htu_plru_tree.sv
logic/bank_htu_set_entry.sv
logic/bank_htu_decode.sv
logic/bank_htu_result.sv
logic/bank_htu_top.sv
tests/bank_htu_tb.sv
